// ==== hdl/bif_bus_pkg.sv ====
//********************************************************************
// bus data package
// word and byte-lane types shared by the bd and lbd sides of the
// bus interface, plus the lane geometry of the transceiver bank
//********************************************************************
package bif_bus_pkg;

   localparam int LANE_W    = 8;  // one transceiver chip is a byte wide
   localparam int NUM_LANES = 3;  // three chips side by side make the word

   // a bus word, active low on bd and true polarity on lbd
   typedef logic [LANE_W*NUM_LANES-1:0] bd_word_t;

   typedef logic [LANE_W-1:0] lane_t;  // the slice of one chip

endpackage

// ==== hdl/bif_ctrl_pkg.sv ====
//********************************************************************
// transfer control package
// configuration word layout, its reset value and the state encoding
// of the transfer sequencer
//********************************************************************
package bif_ctrl_pkg;

   localparam int HOLD_W    = 4;  // width of the drive window field
   localparam int RT_RD_BIT = 4;  // read path passes live bd data
   localparam int RT_WR_BIT = 5;  // write path passes live lbd data
   localparam int CFG_W     = 6;

   typedef logic [HOLD_W-1:0] hold_t;  // window lasts this value plus one cycles
   typedef logic [CFG_W-1:0]  cfg_t;

   // zero hold and stored data in both directions
   localparam cfg_t CFG_RESET = '0;

   // one transfer at a time around the bus grant
   typedef enum logic [1:0] {
      IDLE,   // waiting for xfer_start
      GRANT,  // waiting for bgnt_n low
      DRIVE,  // drive window open
      DONE    // one cycle of xfer_done
   } seq_state_t;

endpackage

// ==== hdl/bif_xcvr_slice.sv ====
//********************************************************************
// registered inverting transceiver, one byte lane
// keeps a stored register per side and drives each side from either
// the live or the stored data of the opposite side, inverted
//********************************************************************
`timescale 1ns/1ps

module bif_xcvr_slice (
   input  logic                clkbd,
   input  logic                rst,
   input  bif_bus_pkg::lane_t  a_n_in,   // bd side, active low
   input  bif_bus_pkg::lane_t  b_in,     // lbd side, true polarity
   input  logic                cap_a,    // load the a register at this edge
   input  logic                cap_b,    // load the b register at this edge
   input  logic                sel_ab,   // b output takes live a data when set
   input  logic                sel_ba,   // a output takes live b data when set
   input  logic                drive_a,
   input  logic                drive_b,
   output bif_bus_pkg::lane_t  a_n_out,
   output bif_bus_pkg::lane_t  b_out
);
   import bif_bus_pkg::*;

   lane_t a_reg;   // stored bd lane, still in bus polarity
   lane_t b_reg;   // stored lbd lane
   lane_t ab_src;  // data headed for the lbd side
   lane_t ba_src;  // data headed for the bd side

   //*****************************************************************
   // capture registers
   //*****************************************************************
   always_ff @(posedge clkbd) begin
      if (rst) begin
         a_reg <= '0;
         b_reg <= '0;
      end else begin
         if (cap_a)
            a_reg <= a_n_in;  // grant edge of a read
         if (cap_b)
            b_reg <= b_in;    // start edge of a write
      end
   end

   //*****************************************************************
   // output muxes, live or stored then inverted
   //*****************************************************************
   assign ab_src = sel_ab ? a_n_in : a_reg;  // real-time or stored read data
   assign ba_src = sel_ba ? b_in : b_reg;    // real-time or stored write data

   // an undriven side reads as zero instead of floating
   assign b_out   = drive_b ? ~ab_src : '0;
   assign a_n_out = drive_a ? ~ba_src : '0;

endmodule

// ==== hdl/bif_bdlbd.sv ====
//********************************************************************
// bd to lbd data path
// three transceiver slices make the 24 bit word, with direction and
// enable decoded once into a drive enable for each side
//********************************************************************
`timescale 1ns/1ps

module bif_bdlbd (
   input  logic                   clkbd,
   input  logic                   rst,
   input  bif_bus_pkg::bd_word_t  bd_n_in,
   input  bif_bus_pkg::bd_word_t  lbd_in,
   input  logic                   cap_a,   // capture bd word
   input  logic                   cap_b,   // capture lbd word
   input  logic                   sel_ab,  // live read data
   input  logic                   sel_ba,  // live write data
   input  logic                   dir_wr,  // high drives bd, low drives lbd
   input  logic                   oe,      // drive window open
   output bif_bus_pkg::bd_word_t  bd_n_out,
   output bif_bus_pkg::bd_word_t  lbd_out,
   output logic                   bd_oe,
   output logic                   lbd_oe
);
   import bif_bus_pkg::*;

   //*****************************************************************
   // direction and enable decode
   //*****************************************************************
   assign bd_oe  = oe & dir_wr;   // write puts lbd data onto the bus
   assign lbd_oe = oe & ~dir_wr;  // read puts bus data onto lbd

   // lanes 23:16, 15:8 and 7:0, one slice each
   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      bif_xcvr_slice bif_xcvr_slice_i (
         .clkbd   (clkbd),
         .rst     (rst),
         .a_n_in  (bd_n_in[i*LANE_W +: LANE_W]),
         .b_in    (lbd_in[i*LANE_W +: LANE_W]),
         .cap_a   (cap_a),
         .cap_b   (cap_b),
         .sel_ab  (sel_ab),
         .sel_ba  (sel_ba),
         .drive_a (bd_oe),
         .drive_b (lbd_oe),
         .a_n_out (bd_n_out[i*LANE_W +: LANE_W]),
         .b_out   (lbd_out[i*LANE_W +: LANE_W])
      );
   end

   // a side only starts driving after the other has been quiet a cycle
   a_turnaround: assert property (@(posedge clkbd) disable iff (rst)
      !(bd_oe && $past(lbd_oe)) && !(lbd_oe && $past(bd_oe)))
      else $error("one side started driving right after the other");

endmodule

// ==== hdl/bif_ctrl_regs.sv ====
//********************************************************************
// transfer configuration register
// written by a one cycle strobe, read back whole, and split into the
// hold and live select fields for the sequencer and data path
//********************************************************************
`timescale 1ns/1ps

module bif_ctrl_regs (
   input  logic                 clkbd,
   input  logic                 rst,
   input  logic                 cfg_we,     // write strobe, one cycle
   input  bif_ctrl_pkg::cfg_t   cfg_wdata,
   output bif_ctrl_pkg::cfg_t   cfg_rdata,
   output bif_ctrl_pkg::hold_t  cfg_hold,   // drive window length minus one
   output logic                 sel_ab,     // rt_rd field
   output logic                 sel_ba      // rt_wr field
);
   import bif_ctrl_pkg::*;

   cfg_t cfg_q;

   always_ff @(posedge clkbd) begin
      if (rst)
         cfg_q <= CFG_RESET;
      else if (cfg_we)
         cfg_q <= cfg_wdata;  // visible from the next cycle
   end

   assign cfg_rdata = cfg_q;
   assign cfg_hold  = cfg_q[HOLD_W-1:0];
   assign sel_ab    = cfg_q[RT_RD_BIT];
   assign sel_ba    = cfg_q[RT_WR_BIT];

   // configuration only moves on a write
   a_cfg_stable: assert property (@(posedge clkbd) disable iff (rst)
      !cfg_we |=> $stable(cfg_q))
      else $error("configuration changed without cfg_we");

endmodule

// ==== hdl/bif_bus_seq.sv ====
//********************************************************************
// transfer sequencer
// waits for the bus grant, fires the capture strobe for the transfer
// direction and holds the drive window open for hold+1 cycles
//********************************************************************
`timescale 1ns/1ps

module bif_bus_seq (
   input  logic                 clkbd,
   input  logic                 rst,
   input  logic                 xfer_start,  // one cycle request
   input  logic                 xfer_wr,     // sampled with xfer_start, 1 is lbd to bd
   input  logic                 bgnt_n,      // grant level, active low
   input  bif_ctrl_pkg::hold_t  cfg_hold,
   output logic                 cap_a,       // capture the bus word
   output logic                 cap_b,       // capture the local word
   output logic                 dir_wr,
   output logic                 oe,
   output logic                 busy,
   output logic                 xfer_done
);
   import bif_ctrl_pkg::*;

   seq_state_t state;
   hold_t      cnt;     // cycles left in the drive window
   logic       dir_q;   // direction latched at start
   logic       start;   // accepted request
   logic       grant;   // grant edge of a waiting transfer

   assign start = (state == IDLE) && xfer_start;   // ignored while busy
   assign grant = (state == GRANT) && !bgnt_n;

   //*****************************************************************
   // state machine and window counter
   //*****************************************************************
   always_ff @(posedge clkbd) begin
      if (rst) begin
         state <= IDLE;
         cnt   <= '0;
         dir_q <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (start) begin
                  dir_q <= xfer_wr;
                  state <= GRANT;
               end
            end
            GRANT: begin
               if (grant) begin
                  cnt   <= cfg_hold;  // window length taken at the grant
                  state <= DRIVE;
               end
            end
            DRIVE: begin
               if (cnt == '0)
                  state <= DONE;
               else
                  cnt <= cnt - 1'b1;
            end
            default: state <= IDLE;   // DONE lasts exactly one cycle
         endcase
      end
   end

   //*****************************************************************
   // strobes and levels
   //*****************************************************************
   assign cap_b     = start && xfer_wr;   // local word taken at the start edge
   assign cap_a     = grant && !dir_q;    // bus word taken at the grant edge
   assign dir_wr    = dir_q;
   assign oe        = (state == DRIVE);
   assign busy      = (state != IDLE);    // falls after the done cycle
   assign xfer_done = (state == DONE);

   a_done_pulse: assert property (@(posedge clkbd) disable iff (rst)
      xfer_done |=> !xfer_done)
      else $error("xfer_done held longer than one cycle");

   // the window only follows a grant, never a fresh start
   a_oe_window: assert property (@(posedge clkbd) disable iff (rst)
      $rose(oe) |-> $past(state) == GRANT && $past(!bgnt_n))
      else $error("drive window opened without a grant");

   a_cap_excl: assert property (@(posedge clkbd) disable iff (rst)
      !(cap_a && cap_b))
      else $error("capture strobes coincide");

endmodule

// ==== hdl/bif_top.sv ====
//********************************************************************
// bus interface data section
// configuration register, transfer sequencer and the inverting
// transceiver path between the bd bus and the local lbd bus
//********************************************************************
`timescale 1ns/1ps

module bif_top (
   input  logic                   clkbd,
   input  logic                   rst,
   input  logic                   cfg_we,
   input  bif_ctrl_pkg::cfg_t     cfg_wdata,
   output bif_ctrl_pkg::cfg_t     cfg_rdata,
   input  logic                   xfer_start,
   input  logic                   xfer_wr,
   input  logic                   bgnt_n,
   input  bif_bus_pkg::bd_word_t  bd_n_in,
   output bif_bus_pkg::bd_word_t  bd_n_out,
   input  bif_bus_pkg::bd_word_t  lbd_in,
   output bif_bus_pkg::bd_word_t  lbd_out,
   output logic                   bd_oe,
   output logic                   lbd_oe,
   output logic                   busy,
   output logic                   xfer_done
);
   import bif_ctrl_pkg::*;

   hold_t cfg_hold;  // drive window length to the sequencer
   logic  sel_ab;    // live read data
   logic  sel_ba;    // live write data
   logic  cap_a;
   logic  cap_b;
   logic  dir_wr;
   logic  oe;

   bif_ctrl_regs bif_ctrl_regs_i (
      .clkbd     (clkbd),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_wdata (cfg_wdata),
      .cfg_rdata (cfg_rdata),
      .cfg_hold  (cfg_hold),
      .sel_ab    (sel_ab),
      .sel_ba    (sel_ba)
   );

   bif_bus_seq bif_bus_seq_i (
      .clkbd      (clkbd),
      .rst        (rst),
      .xfer_start (xfer_start),
      .xfer_wr    (xfer_wr),
      .bgnt_n     (bgnt_n),
      .cfg_hold   (cfg_hold),
      .cap_a      (cap_a),
      .cap_b      (cap_b),
      .dir_wr     (dir_wr),
      .oe         (oe),
      .busy       (busy),
      .xfer_done  (xfer_done)
   );

   bif_bdlbd bif_bdlbd_i (
      .clkbd    (clkbd),
      .rst      (rst),
      .bd_n_in  (bd_n_in),
      .lbd_in   (lbd_in),
      .cap_a    (cap_a),
      .cap_b    (cap_b),
      .sel_ab   (sel_ab),
      .sel_ba   (sel_ba),
      .dir_wr   (dir_wr),
      .oe       (oe),
      .bd_n_out (bd_n_out),
      .lbd_out  (lbd_out),
      .bd_oe    (bd_oe),
      .lbd_oe   (lbd_oe)
   );

endmodule

// ==== tb/bif_top_vectors.svh ====
//**********************************************************************
// transfer table for the bus interface testbench
// one row per transfer with its configuration, data words, grant
// delay, mid-window change and the expected drive window length
//**********************************************************************
`ifndef BIF_TOP_VECTORS_SVH
`define BIF_TOP_VECTORS_SVH

// cfg bit 5 is rt_wr, bit 4 is rt_rd, bits 3:0 the hold field
typedef struct packed {
   logic [5:0]  cfg;      // configuration written before the transfer
   logic        wr;       // 1 moves lbd to bd, 0 moves bd to lbd
   logic [23:0] lbd_w;    // local word driven at the start edge
   logic [23:0] bd_w;     // bus word driven up to the grant edge, active low
   logic [3:0]  gnt_dly;  // cycles of bgnt_n high before the grant
   logic        chg;      // swap in a random source word mid-window
   logic        restart;  // pulse xfer_start again while waiting for grant
   logic [4:0]  exp_len;  // expected drive window, hold plus one
} vec_t;

localparam int NUM_ROWS = 11;

// columns: cfg, wr, lbd_w, bd_w, gnt_dly, chg, restart, exp_len
localparam vec_t VECTORS [NUM_ROWS] = '{
   '{6'h00, 1'b1, 24'h123456, 24'hffffff, 4'd0, 1'b0, 1'b0, 5'd1},   // shortest write
   '{6'h03, 1'b1, 24'ha5c3e1, 24'h0f0f0f, 4'd2, 1'b1, 1'b0, 5'd4},   // stored write, lbd moves
   '{6'h02, 1'b0, 24'h000000, 24'h5a5a5a, 4'd1, 1'b1, 1'b0, 5'd3},   // stored read, bd moves
   '{6'h14, 1'b0, 24'hffffff, 24'hc0ffee, 4'd3, 1'b1, 1'b0, 5'd5},   // live read follows bd
   '{6'h25, 1'b1, 24'h7e7e7e, 24'h000000, 4'd1, 1'b1, 1'b0, 5'd6},   // live write follows lbd
   '{6'h01, 1'b1, 24'h89abcd, 24'h123123, 4'd9, 1'b1, 1'b1, 5'd2},   // long stall, second start
   '{6'h06, 1'b0, 24'h456456, 24'h3c3c3c, 4'd7, 1'b0, 1'b1, 5'd7},   // read stall, second start
   '{6'h1f, 1'b0, 24'h000fff, 24'hfff000, 4'd0, 1'b1, 1'b0, 5'd16},  // longest live read
   '{6'h37, 1'b1, 24'h800001, 24'h7ffffe, 4'd4, 1'b1, 1'b0, 5'd8},   // both live, write side
   '{6'h22, 1'b0, 24'h111111, 24'hedcba9, 4'd2, 1'b1, 1'b0, 5'd3},   // rt_wr has no say on reads
   '{6'h12, 1'b1, 24'h246813, 24'h999999, 4'd1, 1'b1, 1'b0, 5'd3}    // rt_rd has no say on writes
};

`endif

// ==== tb/bif_top_tb.sv ====
//**********************************************************************
// testbench for the bus interface data section
// runs the transfer table through the DUT and checks enables, data,
// window length and the done pulse against the bus timing rules
//**********************************************************************
`timescale 1ns/1ps

module bif_top_tb;

   `include "bif_top_vectors.svh"

   logic        clkbd = 1'b0;
   logic        rst;
   logic        cfg_we;
   logic [5:0]  cfg_wdata;
   logic [5:0]  cfg_rdata;
   logic        xfer_start;
   logic        xfer_wr;
   logic        bgnt_n;
   logic [23:0] bd_n_in;
   logic [23:0] bd_n_out;
   logic [23:0] lbd_in;
   logic [23:0] lbd_out;
   logic        bd_oe;
   logic        lbd_oe;
   logic        busy;
   logic        xfer_done;

   int err_cnt = 0;  // failed checks over the whole run
   int chk_cnt = 0;

   always #10 clkbd = ~clkbd;  // 20 ns period

   bif_top bif_top_i (
      .clkbd      (clkbd),
      .rst        (rst),
      .cfg_we     (cfg_we),
      .cfg_wdata  (cfg_wdata),
      .cfg_rdata  (cfg_rdata),
      .xfer_start (xfer_start),
      .xfer_wr    (xfer_wr),
      .bgnt_n     (bgnt_n),
      .bd_n_in    (bd_n_in),
      .bd_n_out   (bd_n_out),
      .lbd_in     (lbd_in),
      .lbd_out    (lbd_out),
      .bd_oe      (bd_oe),
      .lbd_oe     (lbd_oe),
      .busy       (busy),
      .xfer_done  (xfer_done)
   );

   //*******************************************************************
   // checks
   //*******************************************************************
   task automatic check_val(input string name, input logic [23:0] got,
                            input logic [23:0] exp);
      chk_cnt++;
      assert (got === exp)
      else begin
         $display("mismatch at %t: %s is %h, expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   // nothing driven on either side
   task automatic check_quiet();
      check_val("bd_oe", bd_oe, 24'h0);
      check_val("lbd_oe", lbd_oe, 24'h0);
      check_val("bd_n_out", bd_n_out, 24'h0);
      check_val("lbd_out", lbd_out, 24'h0);
   endtask

   // cycle budget of the whole table, used by the watchdog
   function automatic int run_cycles();
      int cycles;
      cycles = 40;                                     // reset and settling
      for (int r = 0; r < NUM_ROWS; r++)
         cycles += VECTORS[r].gnt_dly + 2 + VECTORS[r].exp_len + 12;
      return cycles;
   endfunction

   //*******************************************************************
   // one transfer, entered and left on a falling edge
   //*******************************************************************
   task automatic run_row(input int r);
      vec_t        v;
      logic [23:0] lbd_w;
      logic [23:0] bd_w;
      int          dly;
      int          n;
      int          err0;
      logic        en;
      v    = VECTORS[r];
      err0 = err_cnt;
      cfg_wdata = v.cfg;                                // config write, one strobe
      cfg_we    = 1'b1;
      @(negedge clkbd);
      cfg_we = 1'b0;
      @(negedge clkbd);
      check_val("cfg_rdata", cfg_rdata, v.cfg);         // new value one cycle later
      check_quiet();
      lbd_w      = v.lbd_w;
      bd_w       = v.bd_w;
      lbd_in     = lbd_w;
      bd_n_in    = bd_w;
      xfer_wr    = v.wr;
      xfer_start = 1'b1;
      @(negedge clkbd);
      xfer_start = 1'b0;
      check_val("busy", busy, 24'h1);
      dly = v.gnt_dly + $urandom_range(2, 0);           // jitter on the grant
      for (int d = 0; d < dly; d++) begin
         check_val("busy", busy, 24'h1);
         check_val("xfer_done", xfer_done, 24'h0);
         check_quiet();                                 // stalled, nothing driven
         xfer_start = v.restart && (d == 0);            // must be ignored
         xfer_wr    = v.restart ? ~v.wr : v.wr;
         @(negedge clkbd);
      end
      xfer_start = 1'b0;
      xfer_wr    = v.wr;
      bgnt_n     = 1'b0;                                // grant edge is the next rise
      @(negedge clkbd);
      bgnt_n = 1'b1;
      en = v.wr ? bd_oe : lbd_oe;
      assert (en)
      else begin
         $display("at %t the drive window did not open after the grant", $time);
         err_cnt++;
      end
      n = 0;
      while (en && n < 20) begin
         n++;
         check_val("bd_oe & lbd_oe", bd_oe & lbd_oe, 24'h0);
         check_val("busy", busy, 24'h1);
         if (v.wr) begin
            check_val("bd_n_out", bd_n_out, v.cfg[5] ? ~lbd_in : ~lbd_w);
            check_val("lbd_out", lbd_out, 24'h0);
         end else begin
            check_val("lbd_out", lbd_out, v.cfg[4] ? ~bd_n_in : ~bd_w);
            check_val("bd_n_out", bd_n_out, 24'h0);
         end
         if (v.chg && n == 1) begin                     // source moves mid-window
            if (v.wr)
               lbd_in = 24'($urandom);
            else
               bd_n_in = 24'($urandom);
         end
         @(negedge clkbd);
         en = v.wr ? bd_oe : lbd_oe;
      end
      assert (n < 20)
      else begin
         $display("at %t the drive window did not close", $time);
         err_cnt++;
      end
      check_val("window length", n, v.exp_len);
      check_val("xfer_done", xfer_done, 24'h1);         // done cycle right after
      check_val("busy", busy, 24'h1);
      check_quiet();
      for (int i = 0; i < 2; i++) begin
         @(negedge clkbd);
         check_val("xfer_done", xfer_done, 24'h0);      // one pulse only
         check_val("busy", busy, 24'h0);
         check_quiet();
      end
      $display("row %0d: %s cfg=%h window=%0d cycles, %0d errors",
               r, v.wr ? "write" : "read", v.cfg, n, err_cnt - err0);
   endtask

   //*******************************************************************
   // main sequence
   //*******************************************************************
   initial begin
      $timeformat(-9, 0, " ns", 0);
      void'($urandom(1336));
      rst        = 1'b1;
      cfg_we     = 1'b0;
      cfg_wdata  = 6'h00;
      xfer_start = 1'b0;
      xfer_wr    = 1'b0;
      bgnt_n     = 1'b1;
      bd_n_in    = 24'hffffff;                          // idle bus floats high
      lbd_in     = 24'h000000;
      repeat (8) @(negedge clkbd);
      rst = 1'b0;
      @(negedge clkbd);
      check_val("cfg_rdata", cfg_rdata, 24'h0);         // hold 0, stored both ways
      check_val("busy", busy, 24'h0);
      check_val("xfer_done", xfer_done, 24'h0);
      check_quiet();
      for (int r = 0; r < NUM_ROWS; r++)
         run_row(r);
      $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, chk_cnt, err_cnt);
      if (err_cnt == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   // watchdog, budget taken from the table
   initial begin
      int limit;
      limit = run_cycles() * 20;
      #(limit);
      $display("watchdog: run did not finish within %0d ns", limit);
      $display("Done: errors found");
      $finish;
   end

endmodule

// ==== bif_top.f ====
+incdir+tb
hdl/bif_bus_pkg.sv
hdl/bif_ctrl_pkg.sv
hdl/bif_xcvr_slice.sv
hdl/bif_bdlbd.sv
hdl/bif_ctrl_regs.sv
hdl/bif_bus_seq.sv
hdl/bif_top.sv
tb/bif_top_tb.sv

// ==== Bender.yml ====
package:
  name: bif_top

sources:
  # packages first, then the data path and control blocks
  - files:
      - hdl/bif_bus_pkg.sv
      - hdl/bif_ctrl_pkg.sv
      - hdl/bif_xcvr_slice.sv
      - hdl/bif_bdlbd.sv
      - hdl/bif_ctrl_regs.sv
      - hdl/bif_bus_seq.sv
      - hdl/bif_top.sv

  # testbench with its transfer table header
  - target: test
    include_dirs:
      - tb
    files:
      - tb/bif_top_tb.sv
